// ==== src/bus_pkg.sv ====
package bus_pkg;

  // one 64-bit AXI data beat, seen whole or as two 32-bit lanes
  typedef union packed {
    logic [63:0] word;
    struct packed {
      logic [31:0] hi;  // addr[2] = 1
      logic [31:0] lo;  // addr[2] = 0
    } lanes;
  } axi_beat_u;

  // xresp
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // axburst
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  // axsize, bytes per beat as log2
  localparam logic [2:0] AXI_SIZE_B = 3'b000;
  localparam logic [2:0] AXI_SIZE_H = 3'b001;
  localparam logic [2:0] AXI_SIZE_W = 3'b010;

  // core-side byte enables, unshifted
  localparam logic [3:0] STRB_B = 4'h1;
  localparam logic [3:0] STRB_H = 4'h3;
  localparam logic [3:0] STRB_W = 4'hf;

endpackage

// ==== src/mem_map_pkg.sv ====
package mem_map_pkg;

  // core-local timer, low and high halves of mtime
  localparam logic [31:0] CLINT_MTIME_LO = 32'h0200_bff8;
  localparam logic [31:0] CLINT_MTIME_HI = 32'h0200_bffc;

  localparam logic [63:0] MTIME_RESET = 64'h0;  // count starts here after rst

endpackage

// ==== src/store_align.sv ====
module store_align #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic [ADDR_W-1:0]  lsu_awaddr_i,
  input  logic [DATA_W-1:0]  lsu_wdata_i,
  input  logic [3:0]         lsu_wstrb_i,
  output bus_pkg::axi_beat_u wdata_o,
  output logic [7:0]         wstrb_o,
  output logic [2:0]         awsize_o
);

  logic [1:0]        byte_off;
  logic [DATA_W-1:0] data_shift;
  logic [7:0]        strb_wide;

  assign byte_off   = lsu_awaddr_i[1:0];
  assign data_shift = lsu_wdata_i << {byte_off, 3'b000};
  assign strb_wide  = {4'b0000, lsu_wstrb_i} << byte_off;

  // slave takes whichever lane the strobe enables
  always_comb
  begin
    wdata_o.lanes.lo = data_shift;
    wdata_o.lanes.hi = data_shift;
  end

  assign wstrb_o = lsu_awaddr_i[2] ? {strb_wide[3:0], 4'b0000}
                                   : {4'b0000, strb_wide[3:0]};

  always_comb
  begin
    case (lsu_wstrb_i)
      bus_pkg::STRB_H: awsize_o = bus_pkg::AXI_SIZE_H;
      bus_pkg::STRB_W: awsize_o = bus_pkg::AXI_SIZE_W;
      default:         awsize_o = bus_pkg::AXI_SIZE_B;  // byte and odd strobes
    endcase
  end

  // a misaligned store from the core would spill into the next lane
  always_comb
  begin
    a_strb_in_lane: assert final ($isunknown(strb_wide) || strb_wide[7:4] == 4'b0000)
      else $error("store strobe %h at offset %0d leaves its lane", lsu_wstrb_i, byte_off);
  end

endmodule

// ==== src/clint_timer.sv ====
module clint_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              arvalid_i,
  input  logic [ADDR_W-1:0] araddr_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              rvalid_o
);

  logic [2*DATA_W-1:0] mtime_q;
  logic                sel_hi;

  assign sel_hi = (araddr_i == ADDR_W'(mem_map_pkg::CLINT_MTIME_HI));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= (2*DATA_W)'(mem_map_pkg::MTIME_RESET);
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 1'b1;  // free running
      rvalid_o <= arvalid_i;
    end
  end

  // half captured on the request cycle
  always_ff @(posedge clk)
  begin
    if (arvalid_i)
      rdata_o <= sel_hi ? mtime_q[DATA_W +: DATA_W] : mtime_q[0 +: DATA_W];
  end

endmodule

// ==== src/bus_arbiter.sv ====
module bus_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                  clk,
  input  logic                  rst,

  // fetch
  input  logic [ADDR_W-1:0]     ifu_araddr_i,
  input  logic                  ifu_arvalid_i,
  output logic [DATA_W-1:0]     ifu_rdata_o,
  output logic                  ifu_rvalid_o,

  // load
  input  logic [ADDR_W-1:0]     lsu_araddr_i,
  input  logic                  lsu_arvalid_i,
  input  logic [3:0]            lsu_rstrb_i,
  output logic [DATA_W-1:0]     lsu_rdata_o,
  output logic                  lsu_rvalid_o,

  // store
  input  logic [ADDR_W-1:0]     lsu_awaddr_i,
  input  logic                  lsu_wvalid_i,
  output logic                  lsu_wready_o,

  // from store_align
  input  bus_pkg::axi_beat_u    aln_wdata_i,
  input  logic [7:0]            aln_wstrb_i,
  input  logic [2:0]            aln_awsize_i,

  // timer
  output logic                  tmr_arvalid_o,
  output logic [ADDR_W-1:0]     tmr_araddr_o,
  input  logic [DATA_W-1:0]     tmr_rdata_i,
  input  logic                  tmr_rvalid_i,

  // axi master
  output logic [ADDR_W-1:0]     m_axi_araddr_o,
  output logic [2:0]            m_axi_arsize_o,
  output logic [7:0]            m_axi_arlen_o,
  output logic [1:0]            m_axi_arburst_o,
  output logic                  m_axi_arvalid_o,
  input  logic                  m_axi_arready_i,
  input  logic [63:0]           m_axi_rdata_i,
  input  logic [1:0]            m_axi_rresp_i,
  input  logic                  m_axi_rvalid_i,
  output logic                  m_axi_rready_o,
  output logic [ADDR_W-1:0]     m_axi_awaddr_o,
  output logic [2:0]            m_axi_awsize_o,
  output logic                  m_axi_awvalid_o,
  input  logic                  m_axi_awready_i,
  output logic [63:0]           m_axi_wdata_o,
  output logic [7:0]            m_axi_wstrb_o,
  output logic                  m_axi_wlast_o,
  output logic                  m_axi_wvalid_o,
  input  logic                  m_axi_wready_i,
  input  logic [1:0]            m_axi_bresp_i,
  input  logic                  m_axi_bvalid_i,
  output logic                  m_axi_bready_o
);

  localparam logic [2:0] IDLE    = 3'd0;
  localparam logic [2:0] FETCH_A = 3'd1;
  localparam logic [2:0] FETCH_D = 3'd2;
  localparam logic [2:0] LS_A    = 3'd3;
  localparam logic [2:0] LD_D    = 3'd4;
  localparam logic [2:0] ST_RESP = 3'd5;

  logic [2:0]         state_q;
  logic               aw_done_q;
  logic               w_done_q;
  logic               ls_req;
  logic               ls_store;
  logic               ls_timer;
  logic               aw_hs;
  logic               w_hs;
  logic               lane_sel;
  logic [DATA_W-1:0]  r_lane;
  bus_pkg::axi_beat_u r_beat;

  assign ls_req   = lsu_arvalid_i | lsu_wvalid_i;
  assign ls_store = lsu_wvalid_i;
  assign ls_timer = !ls_store &
                    ((lsu_araddr_i == ADDR_W'(mem_map_pkg::CLINT_MTIME_LO)) |
                     (lsu_araddr_i == ADDR_W'(mem_map_pkg::CLINT_MTIME_HI)));

  assign aw_hs = m_axi_awvalid_o & m_axi_awready_i;
  assign w_hs  = m_axi_wvalid_o & m_axi_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (ls_req)  // load/store beats fetch
            state_q <= LS_A;
          else if (ifu_arvalid_i)
            state_q <= FETCH_A;
        end
        FETCH_A:
          if (m_axi_arready_i)
            state_q <= FETCH_D;
        FETCH_D:
          if (m_axi_rvalid_i)
            state_q <= IDLE;
        LS_A:
        begin
          if (ls_store)
          begin
            if (aw_hs)
              aw_done_q <= 1'b1;
            if (w_hs)
              w_done_q <= 1'b1;
            if ((aw_done_q | aw_hs) & (w_done_q | w_hs))
              state_q <= ST_RESP;
          end
          else if (ls_timer)
          begin
            if (tmr_rvalid_i)
              state_q <= IDLE;
          end
          else if (m_axi_arready_i)
            state_q <= LD_D;
        end
        LD_D:
          if (m_axi_rvalid_i)
            state_q <= IDLE;
        ST_RESP:
          if (m_axi_bvalid_i)
            state_q <= IDLE;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // read address channel
  assign m_axi_arvalid_o = (state_q == FETCH_A) |
                           ((state_q == LS_A) & !ls_store & !ls_timer);
  assign m_axi_araddr_o  = (state_q == FETCH_A) ? ifu_araddr_i : lsu_araddr_i;
  assign m_axi_arlen_o   = 8'h00;  // single beat
  assign m_axi_arburst_o = bus_pkg::AXI_BURST_INCR;

  always_comb
  begin
    if (state_q == FETCH_A)
      m_axi_arsize_o = bus_pkg::AXI_SIZE_W;
    else
    begin
      case (lsu_rstrb_i)
        bus_pkg::STRB_B: m_axi_arsize_o = bus_pkg::AXI_SIZE_B;
        bus_pkg::STRB_H: m_axi_arsize_o = bus_pkg::AXI_SIZE_H;
        bus_pkg::STRB_W: m_axi_arsize_o = bus_pkg::AXI_SIZE_W;
        default:         m_axi_arsize_o = bus_pkg::AXI_SIZE_B;
      endcase
    end
  end

  // read data, lane picked by addr[2]
  assign m_axi_rready_o = 1'b1;
  assign r_beat.word    = m_axi_rdata_i;
  assign lane_sel       = (state_q == FETCH_D) ? ifu_araddr_i[2] : lsu_araddr_i[2];
  assign r_lane         = lane_sel ? r_beat.lanes.hi : r_beat.lanes.lo;

  assign ifu_rdata_o  = r_lane;
  assign ifu_rvalid_o = (state_q == FETCH_D) & m_axi_rvalid_i;
  assign lsu_rdata_o  = ls_timer ? tmr_rdata_i : r_lane;
  assign lsu_rvalid_o = ((state_q == LD_D) & m_axi_rvalid_i) |
                        ((state_q == LS_A) & ls_timer & tmr_rvalid_i);

  // timer request is a single pulse
  assign tmr_arvalid_o = (state_q == LS_A) & ls_timer & !tmr_rvalid_i;
  assign tmr_araddr_o  = lsu_araddr_i;

  // write channels, aw and w retire independently
  assign m_axi_awvalid_o = (state_q == LS_A) & ls_store & !aw_done_q;
  assign m_axi_awaddr_o  = lsu_awaddr_i;
  assign m_axi_awsize_o  = aln_awsize_i;
  assign m_axi_wvalid_o  = (state_q == LS_A) & ls_store & !w_done_q;
  assign m_axi_wdata_o   = aln_wdata_i.word;
  assign m_axi_wstrb_o   = aln_wstrb_i;
  assign m_axi_wlast_o   = 1'b1;
  assign m_axi_bready_o  = 1'b1;
  assign lsu_wready_o    = (state_q == ST_RESP) & m_axi_bvalid_i;

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_axi_rvalid_i |-> m_axi_rresp_i == bus_pkg::AXI_RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    m_axi_bvalid_i |-> m_axi_bresp_i == bus_pkg::AXI_RESP_OKAY);

  // relies on the core holding its request
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

endmodule

// ==== src/core_bus_top.sv ====
module core_bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,

  input  logic [ADDR_W-1:0] ifu_araddr_i,
  input  logic              ifu_arvalid_i,
  output logic [DATA_W-1:0] ifu_rdata_o,
  output logic              ifu_rvalid_o,

  input  logic [ADDR_W-1:0] lsu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  logic [3:0]        lsu_rstrb_i,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              lsu_rvalid_o,

  input  logic [ADDR_W-1:0] lsu_awaddr_i,
  input  logic [DATA_W-1:0] lsu_wdata_i,
  input  logic [3:0]        lsu_wstrb_i,
  input  logic              lsu_wvalid_i,
  output logic              lsu_wready_o,

  output logic [ADDR_W-1:0] m_axi_araddr_o,
  output logic [2:0]        m_axi_arsize_o,
  output logic [7:0]        m_axi_arlen_o,
  output logic [1:0]        m_axi_arburst_o,
  output logic              m_axi_arvalid_o,
  input  logic              m_axi_arready_i,
  input  logic [63:0]       m_axi_rdata_i,
  input  logic [1:0]        m_axi_rresp_i,
  input  logic              m_axi_rvalid_i,
  output logic              m_axi_rready_o,
  output logic [ADDR_W-1:0] m_axi_awaddr_o,
  output logic [2:0]        m_axi_awsize_o,
  output logic              m_axi_awvalid_o,
  input  logic              m_axi_awready_i,
  output logic [63:0]       m_axi_wdata_o,
  output logic [7:0]        m_axi_wstrb_o,
  output logic              m_axi_wlast_o,
  output logic              m_axi_wvalid_o,
  input  logic              m_axi_wready_i,
  input  logic [1:0]        m_axi_bresp_i,
  input  logic              m_axi_bvalid_i,
  output logic              m_axi_bready_o
);

  bus_pkg::axi_beat_u aln_wdata;
  logic [7:0]         aln_wstrb;
  logic [2:0]         aln_awsize;
  logic               tmr_arvalid;
  logic [ADDR_W-1:0]  tmr_araddr;
  logic [DATA_W-1:0]  tmr_rdata;
  logic               tmr_rvalid;

  store_align #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_store_align (
    .lsu_awaddr_i (lsu_awaddr_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_wstrb_i  (lsu_wstrb_i),
    .wdata_o      (aln_wdata),
    .wstrb_o      (aln_wstrb),
    .awsize_o     (aln_awsize)
  );

  clint_timer #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_clint_timer (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (tmr_arvalid),
    .araddr_i  (tmr_araddr),
    .rdata_o   (tmr_rdata),
    .rvalid_o  (tmr_rvalid)
  );

  bus_arbiter #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_bus_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_araddr_i    (ifu_araddr_i),
    .ifu_arvalid_i   (ifu_arvalid_i),
    .ifu_rdata_o     (ifu_rdata_o),
    .ifu_rvalid_o    (ifu_rvalid_o),
    .lsu_araddr_i    (lsu_araddr_i),
    .lsu_arvalid_i   (lsu_arvalid_i),
    .lsu_rstrb_i     (lsu_rstrb_i),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_rvalid_o    (lsu_rvalid_o),
    .lsu_awaddr_i    (lsu_awaddr_i),
    .lsu_wvalid_i    (lsu_wvalid_i),
    .lsu_wready_o    (lsu_wready_o),
    .aln_wdata_i     (aln_wdata),
    .aln_wstrb_i     (aln_wstrb),
    .aln_awsize_i    (aln_awsize),
    .tmr_arvalid_o   (tmr_arvalid),
    .tmr_araddr_o    (tmr_araddr),
    .tmr_rdata_i     (tmr_rdata),
    .tmr_rvalid_i    (tmr_rvalid),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arsize_o  (m_axi_arsize_o),
    .m_axi_arlen_o   (m_axi_arlen_o),
    .m_axi_arburst_o (m_axi_arburst_o),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .m_axi_awaddr_o  (m_axi_awaddr_o),
    .m_axi_awsize_o  (m_axi_awsize_o),
    .m_axi_awvalid_o (m_axi_awvalid_o),
    .m_axi_awready_i (m_axi_awready_i),
    .m_axi_wdata_o   (m_axi_wdata_o),
    .m_axi_wstrb_o   (m_axi_wstrb_o),
    .m_axi_wlast_o   (m_axi_wlast_o),
    .m_axi_wvalid_o  (m_axi_wvalid_o),
    .m_axi_wready_i  (m_axi_wready_i),
    .m_axi_bresp_i   (m_axi_bresp_i),
    .m_axi_bvalid_i  (m_axi_bvalid_i),
    .m_axi_bready_o  (m_axi_bready_o)
  );

endmodule

// ==== tb/axi_mem_model.sv ====
module axi_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  output integer      write_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  integer      seed;
  logic        rd_pend;
  logic        aw_got;
  logic        w_got;
  logic [31:0] rd_base;

  initial
  begin
    seed          = 32'h33ef8cec;
    write_count_o <= 0;
    rd_pend       <= 1'b0;
    aw_got        <= 1'b0;
    w_got         <= 1'b0;
    rd_base       <= '0;
    arready_o     <= 1'b0;
    rvalid_o      <= 1'b0;
    rdata_o       <= '0;
    awready_o     <= 1'b0;
    wready_o      <= 1'b0;
    bvalid_o      <= 1'b0;
  end

  assign rresp_o = 2'b00;
  assign bresp_o = 2'b00;

  // handshakes seen at the rising edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      rd_pend <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
    end
    else
    begin
      if (arvalid_i && arready_o)
      begin
        rd_pend <= 1'b1;
        rd_base <= {araddr_i[31:3], 3'b000};
      end
      if (rvalid_o && rready_i)
        rd_pend <= 1'b0;
      if (awvalid_i && awready_o)
        aw_got <= 1'b1;
      if (wvalid_i && wready_o)
      begin
        w_got         <= 1'b1;
        write_count_o <= write_count_o + 1;
      end
      if (bvalid_o && bready_i)
      begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
    end
  end

  // random delays, outputs change on the falling edge
  always @(negedge clk)
  begin
    arready_o <= !rd_pend && ($random(seed) & 1);
    rvalid_o  <= rd_pend && (rvalid_o || (($random(seed) & 3) == 0));
    rdata_o   <= {rd_base + 32'd4 ^ 32'ha5a5_0000, rd_base ^ 32'ha5a5_0000};
    awready_o <= !aw_got && ($random(seed) & 1);
    wready_o  <= !w_got && ($random(seed) & 1);
    bvalid_o  <= aw_got && w_got && (bvalid_o || ($random(seed) & 1));
  end

endmodule

// ==== tb/bus_checker.sv ====
module bus_checker (
  input logic        clk,
  input logic        rst,
  input logic [2:0]  arb_state_i,
  input logic [31:0] ifu_araddr_i,
  input logic        ifu_arvalid_i,
  input logic [31:0] ifu_rdata_i,
  input logic        ifu_rvalid_i,
  input logic [31:0] lsu_araddr_i,
  input logic        lsu_arvalid_i,
  input logic [3:0]  lsu_rstrb_i,
  input logic [31:0] lsu_rdata_i,
  input logic        lsu_rvalid_i,
  input logic [31:0] lsu_awaddr_i,
  input logic [31:0] lsu_wdata_i,
  input logic [3:0]  lsu_wstrb_i,
  input logic        lsu_wvalid_i,
  input logic        lsu_wready_i,
  input logic [31:0] m_axi_araddr_i,
  input logic [2:0]  m_axi_arsize_i,
  input logic [7:0]  m_axi_arlen_i,
  input logic [1:0]  m_axi_arburst_i,
  input logic        m_axi_arvalid_i,
  input logic        m_axi_arready_i,
  input logic        m_axi_rready_i,
  input logic [31:0] m_axi_awaddr_i,
  input logic [2:0]  m_axi_awsize_i,
  input logic        m_axi_awvalid_i,
  input logic        m_axi_awready_i,
  input logic [63:0] m_axi_wdata_i,
  input logic [7:0]  m_axi_wstrb_i,
  input logic        m_axi_wlast_i,
  input logic        m_axi_wvalid_i,
  input logic        m_axi_wready_i,
  input logic        m_axi_bvalid_i,
  input logic        m_axi_bready_i,
  input integer      write_count_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_FETCH_A = 3'd1;
  localparam logic [2:0] ST_LS_A    = 3'd3;
  localparam logic [31:0] MTIME_LO = 32'h0200_bff8;
  localparam logic [31:0] MTIME_HI = 32'h0200_bffc;

  integer      err_count = 0;
  integer      proto_count = 0;
  integer      store_done = 0;
  logic        seen_req = 1'b0;
  logic        expect_ls = 1'b0;
  logic        tmr_active = 1'b0;
  integer      tmr_age = 0;
  logic [31:0] tmr_hi_seen = '0;
  logic [63:0] tmr_prev = '0;

  function automatic logic [31:0] exp_read_word(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return addr[2] ? (base + 32'd4) ^ 32'ha5a5_0000 : base ^ 32'ha5a5_0000;
  endfunction

  function automatic logic [63:0] exp_wdata(input logic [31:0] addr, input logic [31:0] d);
    logic [31:0] s;
    s = d << (8 * addr[1:0]);
    return {s, s};
  endfunction

  function automatic logic [7:0] exp_wstrb(input logic [31:0] addr, input logic [3:0] strb);
    logic [7:0] s;
    s = {4'h0, strb} << addr[1:0];
    return addr[2] ? {s[3:0], 4'h0} : {4'h0, s[3:0]};
  endfunction

  function automatic logic [2:0] exp_awsize(input logic [3:0] strb);
    if (strb == 4'h3)
      return 3'd1;
    else if (strb == 4'hf)
      return 3'd2;
    return 3'd0;
  endfunction

  function automatic logic is_timer(input logic [31:0] addr);
    return addr == MTIME_LO || addr == MTIME_HI;
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("** Error [%s] expected %h actual %h at %0t", name, exp, act, $time);
      err_count++;
    end
  endtask

  task automatic flag(input string what);
    $display("%s at %0t", what, $time);
    proto_count++;
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (!seen_req && (m_axi_arvalid_i || m_axi_awvalid_i || m_axi_wvalid_i ||
                        ifu_rvalid_i || lsu_rvalid_i || lsu_wready_i))
        flag("a valid or response went high before any request");
      if (ifu_arvalid_i || lsu_arvalid_i || lsu_wvalid_i)
        seen_req = 1'b1;

      if (m_axi_rready_i !== 1'b1 || m_axi_bready_i !== 1'b1)
        flag("rready or bready is not held high");

      // load/store must win over a pending fetch
      if (expect_ls && arb_state_i != ST_LS_A)
        flag("fetch was granted ahead of a pending load or store");
      expect_ls = arb_state_i == ST_IDLE && ifu_arvalid_i && (lsu_arvalid_i || lsu_wvalid_i);

      if (m_axi_arvalid_i && m_axi_arready_i)
      begin
        if (arb_state_i == ST_FETCH_A)
        begin
          compare("ar_addr", ifu_araddr_i, m_axi_araddr_i);
          compare("ar_size", 3'd2, m_axi_arsize_i);  // fetch is always a word
        end
        else
        begin
          compare("ar_addr", lsu_araddr_i, m_axi_araddr_i);
          compare("ar_size", exp_awsize(lsu_rstrb_i), m_axi_arsize_i);
        end
        compare("ar_len", 8'h00, m_axi_arlen_i);
        compare("ar_burst", 2'b01, m_axi_arburst_i);
      end

      if (ifu_rvalid_i)
      begin
        if (!ifu_arvalid_i)
          flag("fetch response without a fetch request");
        compare("fetch", exp_read_word(ifu_araddr_i), ifu_rdata_i);
      end

      if (m_axi_arvalid_i && is_timer(m_axi_araddr_i))
        flag("timer load reached the AXI read channel");

      if (tmr_active)
        tmr_age++;
      if (lsu_rvalid_i)
      begin
        if (!lsu_arvalid_i)
          flag("load response without a load request");
        if (is_timer(lsu_araddr_i))
        begin
          if (!tmr_active || tmr_age != 2)
            flag("timer load latency is not 2 cycles after grant");
          tmr_active = 1'b0;
          if (lsu_araddr_i == MTIME_LO)
          begin
            if ({tmr_hi_seen, lsu_rdata_i} <= tmr_prev)
              compare("mtime_increase", tmr_prev + 64'd1, {tmr_hi_seen, lsu_rdata_i});
            tmr_prev = {tmr_hi_seen, lsu_rdata_i};
          end
          else
          begin
            if (lsu_rdata_i < tmr_hi_seen)
              compare("mtime_hi", {32'h0, tmr_hi_seen}, {32'h0, lsu_rdata_i});
            tmr_hi_seen = lsu_rdata_i;
          end
        end
        else
          compare("load", exp_read_word(lsu_araddr_i), lsu_rdata_i);
      end
      if (arb_state_i == ST_IDLE && lsu_arvalid_i && !lsu_wvalid_i && is_timer(lsu_araddr_i))
      begin
        tmr_active = 1'b1;  // grant edge
        tmr_age    = 0;
      end

      if (m_axi_awvalid_i && m_axi_awready_i)
      begin
        compare("store_awaddr", lsu_awaddr_i, m_axi_awaddr_i);
        compare("store_awsize", exp_awsize(lsu_wstrb_i), m_axi_awsize_i);
      end
      if (m_axi_wvalid_i && m_axi_wready_i)
      begin
        compare("store_wdata", exp_wdata(lsu_awaddr_i, lsu_wdata_i), m_axi_wdata_i);
        compare("store_wstrb", exp_wstrb(lsu_awaddr_i, lsu_wstrb_i), m_axi_wstrb_i);
        compare("store_wlast", 1'b1, m_axi_wlast_i);
      end
      if (lsu_wready_i !== m_axi_bvalid_i)
        flag("store ready does not match the B handshake");
      if (lsu_wready_i && !lsu_wvalid_i)
        flag("store ready without a store request");
      if (lsu_wready_i)
      begin
        // one W beat per completed store
        compare("store_writes", store_done + 1, write_count_i);
        store_done++;
      end
    end
  end

endmodule

// ==== tb/tb_top.sv ====
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TMO = 300;  // cycles per wait

  logic        clk;
  logic        rst;
  logic [31:0] ifu_araddr, lsu_araddr, lsu_awaddr, lsu_wdata;
  logic        ifu_arvalid, lsu_arvalid, lsu_wvalid;
  logic [3:0]  lsu_rstrb, lsu_wstrb;
  logic [31:0] ifu_rdata, lsu_rdata;
  logic        ifu_rvalid, lsu_rvalid, lsu_wready;
  logic [31:0] araddr, awaddr;
  logic [2:0]  arsize, awsize;
  logic [7:0]  arlen, wstrb;
  logic [1:0]  arburst, rresp, bresp;
  logic        arvalid, arready, rvalid, rready, awvalid, awready;
  logic        wvalid, wready, wlast, bvalid, bready;
  logic [63:0] rdata, wdata;
  integer      write_count;
  integer      seed;
  integer      tmo_count;

  core_bus_top #(
    .ADDR_W (32),
    .DATA_W (32)
  ) u_core_bus_top (
    .clk (clk), .rst (rst),
    .ifu_araddr_i (ifu_araddr), .ifu_arvalid_i (ifu_arvalid),
    .ifu_rdata_o (ifu_rdata), .ifu_rvalid_o (ifu_rvalid),
    .lsu_araddr_i (lsu_araddr), .lsu_arvalid_i (lsu_arvalid), .lsu_rstrb_i (lsu_rstrb),
    .lsu_rdata_o (lsu_rdata), .lsu_rvalid_o (lsu_rvalid),
    .lsu_awaddr_i (lsu_awaddr), .lsu_wdata_i (lsu_wdata), .lsu_wstrb_i (lsu_wstrb),
    .lsu_wvalid_i (lsu_wvalid), .lsu_wready_o (lsu_wready),
    .m_axi_araddr_o (araddr), .m_axi_arsize_o (arsize), .m_axi_arlen_o (arlen),
    .m_axi_arburst_o (arburst), .m_axi_arvalid_o (arvalid), .m_axi_arready_i (arready),
    .m_axi_rdata_i (rdata), .m_axi_rresp_i (rresp), .m_axi_rvalid_i (rvalid),
    .m_axi_rready_o (rready), .m_axi_awaddr_o (awaddr), .m_axi_awsize_o (awsize),
    .m_axi_awvalid_o (awvalid), .m_axi_awready_i (awready), .m_axi_wdata_o (wdata),
    .m_axi_wstrb_o (wstrb), .m_axi_wlast_o (wlast), .m_axi_wvalid_o (wvalid),
    .m_axi_wready_i (wready), .m_axi_bresp_i (bresp), .m_axi_bvalid_i (bvalid),
    .m_axi_bready_o (bready)
  );

  axi_mem_model u_mem (
    .clk (clk), .rst (rst), .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
    .awvalid_i (awvalid), .awready_o (awready),
    .wvalid_i (wvalid), .wready_o (wready), .bresp_o (bresp), .bvalid_o (bvalid),
    .bready_i (bready), .write_count_o (write_count)
  );

  bus_checker u_checker (
    .clk (clk), .rst (rst), .arb_state_i (u_core_bus_top.u_bus_arbiter.state_q),
    .ifu_araddr_i (ifu_araddr), .ifu_arvalid_i (ifu_arvalid), .ifu_rdata_i (ifu_rdata),
    .ifu_rvalid_i (ifu_rvalid), .lsu_araddr_i (lsu_araddr), .lsu_arvalid_i (lsu_arvalid),
    .lsu_rstrb_i (lsu_rstrb), .lsu_rdata_i (lsu_rdata), .lsu_rvalid_i (lsu_rvalid),
    .lsu_awaddr_i (lsu_awaddr), .lsu_wdata_i (lsu_wdata), .lsu_wstrb_i (lsu_wstrb),
    .lsu_wvalid_i (lsu_wvalid), .lsu_wready_i (lsu_wready),
    .m_axi_araddr_i (araddr), .m_axi_arsize_i (arsize), .m_axi_arlen_i (arlen),
    .m_axi_arburst_i (arburst), .m_axi_arvalid_i (arvalid), .m_axi_arready_i (arready),
    .m_axi_rready_i (rready), .m_axi_awaddr_i (awaddr), .m_axi_awsize_i (awsize),
    .m_axi_awvalid_i (awvalid), .m_axi_awready_i (awready), .m_axi_wdata_i (wdata),
    .m_axi_wstrb_i (wstrb), .m_axi_wlast_i (wlast), .m_axi_wvalid_i (wvalid),
    .m_axi_wready_i (wready), .m_axi_bvalid_i (bvalid), .m_axi_bready_i (bready),
    .write_count_i (write_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic end_run();
    $display("errors: value %0d, protocol %0d, timeouts %0d",
             u_checker.err_count, u_checker.proto_count, tmo_count);
    if (u_checker.err_count == 0 && u_checker.proto_count == 0 && tmo_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("timeout waiting for %s response at %0t", what, $time);
    tmo_count++;
    end_run();
  endtask

  task automatic do_fetch(input logic [31:0] addr);
    int n;
    @(negedge clk);
    ifu_araddr  = addr;
    ifu_arvalid = 1'b1;
    for (n = 0; n < TMO; n++)
    begin
      @(posedge clk);
      if (ifu_rvalid)
        break;
    end
    if (n == TMO)
      timed_out("fetch");
    else
    begin
      @(negedge clk);
      ifu_arvalid = 1'b0;
    end
  endtask

  task automatic do_load(input logic [31:0] addr, input logic [3:0] strb);
    int n;
    @(negedge clk);
    lsu_araddr  = addr;
    lsu_rstrb   = strb;
    lsu_arvalid = 1'b1;
    for (n = 0; n < TMO; n++)
    begin
      @(posedge clk);
      if (lsu_rvalid)
        break;
    end
    if (n == TMO)
      timed_out("load");
    else
    begin
      @(negedge clk);
      lsu_arvalid = 1'b0;
    end
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [31:0] d, input logic [3:0] strb);
    int n;
    @(negedge clk);
    lsu_awaddr = addr;
    lsu_wdata  = d;
    lsu_wstrb  = strb;
    lsu_wvalid = 1'b1;
    for (n = 0; n < TMO; n++)
    begin
      @(posedge clk);
      if (lsu_wready)
        break;
    end
    if (n == TMO)
      timed_out("store");
    else
    begin
      @(negedge clk);
      lsu_wvalid = 1'b0;
    end
  endtask

  task automatic random_lsu_op();
    logic [31:0] a;
    int kind;
    a    = 32'h1000_0000 | ($random(seed) & 32'h0000_fff8);
    kind = $random(seed) & 3;
    case (kind)
      0: do_load(a | ($random(seed) & 4), ($random(seed) & 1) ? 4'h3 : 4'hf);
      1: do_store(a | ($random(seed) & 7), $random(seed), 4'h1);
      2: do_store(a | ($random(seed) & 4) | 2, $random(seed), 4'h3);
      default: do_load(($random(seed) & 1) ? 32'h0200_bffc : 32'h0200_bff8, 4'hf);
    endcase
  endtask

  initial
  begin
    seed        = 32'h33ef8cec;
    tmo_count   = 0;
    rst         = 1'b1;
    ifu_araddr  = '0;
    ifu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_arvalid = 1'b0;
    lsu_rstrb   = 4'hf;
    lsu_awaddr  = '0;
    lsu_wdata   = '0;
    lsu_wstrb   = 4'h0;
    lsu_wvalid  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (6) @(negedge clk);  // quiet bus after reset

    for (int i = 0; i < 8; i++)
      do_fetch(32'h8000_0000 + 4 * i);

    // fetch and load raised together from IDLE
    fork
      do_fetch(32'h8000_0104);
      do_load(32'h1000_0040, 4'hf);
    join
    do_load(32'h1000_0044, 4'h1);  // byte load, hi lane

    for (int ofs = 0; ofs < 8; ofs++)
      do_store(32'h1000_0100 + ofs, 32'hc3d2_e1f0 + ofs, 4'h1);
    for (int ofs = 0; ofs < 3; ofs++)
    begin
      do_store(32'h1000_0200 + ofs, 32'h0000_beef, 4'h3);
      do_store(32'h1000_0204 + ofs, 32'h0000_cafe, 4'h3);
    end
    do_store(32'h1000_0300, 32'h1234_5678, 4'hf);
    do_store(32'h1000_0304, 32'h9abc_def0, 4'hf);

    for (int i = 0; i < 3; i++)
    begin
      do_load(32'h0200_bff8, 4'hf);
      do_load(32'h0200_bffc, 4'hf);
    end

    fork
      for (int i = 0; i < 40; i++)
        do_fetch(32'h8000_0000 | ($random(seed) & 32'h0000_fffc));
      for (int i = 0; i < 40; i++)
        random_lsu_op();
    join

    repeat (4) @(negedge clk);
    end_run();
  end

endmodule

// ==== compile.f ====
src/bus_pkg.sv
src/mem_map_pkg.sv
src/store_align.sv
src/clint_timer.sv
src/bus_arbiter.sv
src/core_bus_top.sv
tb/axi_mem_model.sv
tb/bus_checker.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
